// ==== bench/raster_assertions.sv ====
`timescale 1ns/1ps

`include "raster_config.svh"

module raster_assertions import raster_pkg::*; (
	input logic        clk,
	input logic        srst_n,
	input logic        tri_valid,
	input logic        tri_ready,
	input depth_t      tri_depth,
	input color_t      tri_color,
	input logic        rd_en,
	input sram_addr_t  rd_addr,
	input logic        wr_en_n,
	input sram_addr_t  wr_addr,
	input logic [`RASTER_TILE_PIX*`RASTER_COLOR_W-1:0] color_word,
	input tile_depth_u depth_after
);
	localparam int PIX = `RASTER_TILE_PIX;
	localparam int WR_DELAY = `RASTER_RD_LATENCY + 1; // read to write

	logic in_reset = 1'b0; // reset was low on the previous edge
	logic [WR_DELAY-1:0] en_d = '0;
	sram_addr_t addr_d [WR_DELAY];
	logic [1:0] acc_d = '0;
	depth_t acc_depth;
	color_t acc_color;
	logic bad_reset = 1'b0;
	logic bad_ready = 1'b0;
	logic bad_first = 1'b0;
	logic bad_busy = 1'b0;
	logic bad_pair = 1'b0;
	logic bad_addr = 1'b0;
	logic bad_depth = 1'b0;
	logic bad_color = 1'b0;
	logic fail_seen;

	assign fail_seen = |{bad_reset, bad_ready, bad_first, bad_busy,
		bad_pair, bad_addr, bad_depth, bad_color};

	always @(posedge clk) begin
		in_reset <= !srst_n;
		en_d <= {en_d[WR_DELAY-2:0], rd_en};
		addr_d[0] <= rd_addr;
		for (int s = 1; s < WR_DELAY; s++)
			addr_d[s] <= addr_d[s-1];
		acc_d <= {acc_d[0], tri_valid && tri_ready};
		if (tri_valid && tri_ready) begin
			acc_depth <= tri_depth;
			acc_color <= tri_color;
		end
	end

	reset_values: assert property (@(posedge clk) in_reset |-> wr_en_n && !rd_en && tri_ready)
		else begin $error("outputs not at their reset values"); bad_reset <= 1'b1; end
	accept_drops_ready: assert property (@(posedge clk) disable iff (!srst_n)
		tri_valid && tri_ready |=> !tri_ready)
		else begin $error("tri_ready still high after a transfer"); bad_ready <= 1'b1; end
	first_read: assert property (@(posedge clk) disable iff (!srst_n) acc_d[1] |-> rd_en)
		else begin $error("no tile read two cycles after acceptance"); bad_first <= 1'b1; end
	read_when_busy: assert property (@(posedge clk) disable iff (!srst_n) rd_en |-> !tri_ready)
		else begin $error("tile read while tri_ready is high"); bad_busy <= 1'b1; end
	write_per_read: assert property (@(posedge clk) disable iff (!srst_n)
		(!wr_en_n) == en_d[WR_DELAY-1])
		else begin $error("write and read do not pair up three cycles apart"); bad_pair <= 1'b1; end
	write_addr: assert property (@(posedge clk) disable iff (!srst_n)
		!wr_en_n |-> wr_addr == addr_d[WR_DELAY-1])
		else begin
			$error("MISMATCH write_addr expected %0h actual %0h",
				$sampled(addr_d[WR_DELAY-1]), $sampled(wr_addr));
			bad_addr <= 1'b1;
		end
	depth_lanes: assert property (@(posedge clk) disable iff (!srst_n)
		!wr_en_n |-> depth_after.flat == {PIX{acc_depth}})
		else begin
			$error("MISMATCH depth_lanes expected %0h actual %0h",
				$sampled(acc_depth), $sampled(depth_after.flat));
			bad_depth <= 1'b1;
		end
	color_lanes: assert property (@(posedge clk) disable iff (!srst_n)
		!wr_en_n |-> color_word == {PIX{acc_color}})
		else begin
			$error("MISMATCH color_lanes expected %0h actual %0h",
				$sampled(acc_color), $sampled(color_word));
			bad_color <= 1'b1;
		end

endmodule

// ==== bench/raster_tb.sv ====
`timescale 1ns/1ps

`include "raster_config.svh"

module raster_tb import raster_pkg::*; ();
	localparam int PIX = `RASTER_TILE_PIX;
	localparam int DIM = `RASTER_TILE_DIM;
	localparam int DW = `RASTER_DEPTH_W;
	localparam int CW = `RASTER_COLOR_W;
	localparam int LAT = `RASTER_RD_LATENCY;
	localparam int WORDS = 1 << `RASTER_ADDR_W;
	localparam int NUM_TRI = 6;

	// both windings and a single tile triangle
	// triangles 3 and 4 land on pixels already written by 0 and 1
	int tri_vx [NUM_TRI][3] = '{'{10, 45, 20}, '{100, 70, 130}, '{33, 35, 34},
		'{15, 40, 22}, '{90, 120, 95}, '{150, 150, 180}};
	int tri_vy [NUM_TRI][3] = '{'{5, 30, 50}, '{20, 60, 45}, '{65, 66, 67},
		'{20, 28, 40}, '{30, 40, 58}, '{150, 180, 150}};
	int tri_z [NUM_TRI] = '{0, -300000, 200000, 0, -1000, 700000};
	int tri_rgb [NUM_TRI] = '{'h20c040, 'hff0000, 'h00ff00, 'h0000ff, 'h808080, 'hfedcba};

	logic clk;
	logic srst_n;
	logic tri_valid;
	logic tri_ready;
	coord_t x1, y1, x2, y2, x3, y3;
	depth_t tri_depth;
	color_t tri_color;
	logic rd_en;
	sram_addr_t rd_addr;
	tile_depth_u depth_org;
	logic wr_en_n;
	sram_addr_t wr_addr;
	pix_mask_t wr_mask_n;
	logic [PIX*CW-1:0] color_word;
	tile_depth_u depth_after;

	logic [PIX*DW-1:0] mem [WORDS]; // one depth word per tile
	sram_addr_t rd_pipe [LAT-1];
	int cur_vx [3];
	int cur_vy [3];
	int cur_z;
	int cyc = 0;
	int acc_cyc = 0;
	int pending = 0;
	logic busy = 1'b0;
	logic ready_due = 1'b0;
	logic rd_started = 1'b0;
	sram_addr_t exp_rd_q [$];
	int exp_tx_q [$];
	int exp_ty_q [$];
	sram_addr_t exp_wr_addr_q [$];
	pix_mask_t exp_wr_mask_q [$];
	int exp_wr_cyc_q [$];

	raster_top raster_top_i (
		.clk, .srst_n, .tri_valid, .tri_ready, .x1, .y1, .x2, .y2, .x3, .y3,
		.tri_depth, .tri_color, .rd_en, .rd_addr, .depth_org,
		.wr_en_n, .wr_addr, .wr_mask_n, .color_word, .depth_after
	);

	bind raster_top raster_assertions raster_assertions_i (
		.clk, .srst_n, .tri_valid, .tri_ready, .tri_depth, .tri_color,
		.rd_en, .rd_addr, .wr_en_n, .wr_addr, .color_word, .depth_after
	);

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string test, input logic [PIX*CW-1:0] exp_v,
			input logic [PIX*CW-1:0] act_v);
		fail_run($sformatf("MISMATCH %s expected %0h actual %0h", test, exp_v, act_v));
	endtask

	function automatic int lowest3(input int a, input int b, input int c);
		return (a < b) ? ((a < c) ? a : c) : ((b < c) ? b : c);
	endfunction

	function automatic int highest3(input int a, input int b, input int c);
		return (a > b) ? ((a > c) ? a : c) : ((b > c) ? b : c);
	endfunction

	function automatic int snap_down(input int v);
		return v & ~(DIM - 1); // floor to tile grid
	endfunction

	function automatic int box_tiles(input int k);
		int cols;
		int rows;
		cols = (snap_down(highest3(tri_vx[k][0], tri_vx[k][1], tri_vx[k][2])) -
			snap_down(lowest3(tri_vx[k][0], tri_vx[k][1], tri_vx[k][2]))) / DIM + 1;
		rows = (snap_down(highest3(tri_vy[k][0], tri_vy[k][1], tri_vy[k][2])) -
			snap_down(lowest3(tri_vy[k][0], tri_vy[k][1], tri_vy[k][2]))) / DIM + 1;
		return cols * rows;
	endfunction

	// edge pixels count as inside for either winding
	function automatic logic inside_tri(input int px, input int py);
		longint e [3];
		for (int k = 0; k < 3; k++)
			e[k] = longint'(cur_vx[(k+1)%3] - cur_vx[k]) * (py - cur_vy[k]) -
				longint'(cur_vy[(k+1)%3] - cur_vy[k]) * (px - cur_vx[k]);
		return (e[0] >= 0 && e[1] >= 0 && e[2] >= 0) || (e[0] <= 0 && e[1] <= 0 && e[2] <= 0);
	endfunction

	function automatic pix_mask_t expect_mask(input int tx, input int ty,
			input logic [PIX*DW-1:0] stored);
		pix_mask_t m;
		int b;
		depth_t lane;
		m = '1;
		for (int dy = 0; dy < DIM; dy++) begin
			for (int dx = 0; dx < DIM; dx++) begin
				b = PIX - 1 - (dy * DIM + dx); // bit 15 is the top left pixel
				lane = stored[b*DW +: DW];
				if (inside_tri(tx + dx, ty + dy) && depth_t'(cur_z) < lane)
					m[b] = 1'b0;
			end
		end
		return m;
	endfunction

	task automatic plan_tiles();
		int lo_x;
		int hi_x;
		int lo_y;
		int hi_y;
		lo_x = snap_down(lowest3(cur_vx[0], cur_vx[1], cur_vx[2]));
		hi_x = snap_down(highest3(cur_vx[0], cur_vx[1], cur_vx[2]));
		lo_y = snap_down(lowest3(cur_vy[0], cur_vy[1], cur_vy[2]));
		hi_y = snap_down(highest3(cur_vy[0], cur_vy[1], cur_vy[2]));
		for (int ty = lo_y; ty <= hi_y; ty += DIM) begin
			for (int tx = lo_x; tx <= hi_x; tx += DIM) begin
				exp_rd_q.push_back(sram_addr_t'(tx / DIM + `RASTER_TILES_PER_ROW * (ty / DIM)));
				exp_tx_q.push_back(tx);
				exp_ty_q.push_back(ty);
			end
		end
		pending = exp_rd_q.size();
	endtask

	task automatic send_triangle(input int k);
		@(posedge clk);
		tri_valid <= 1'b1;
		x1 <= coord_t'(tri_vx[k][0]);
		y1 <= coord_t'(tri_vy[k][0]);
		x2 <= coord_t'(tri_vx[k][1]);
		y2 <= coord_t'(tri_vy[k][1]);
		x3 <= coord_t'(tri_vx[k][2]);
		y3 <= coord_t'(tri_vy[k][2]);
		tri_depth <= depth_t'(tri_z[k]);
		tri_color <= color_t'(tri_rgb[k]);
		@(posedge clk);
		while (!tri_ready)
			@(posedge clk);
		tri_valid <= 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// sram read data LAT cycles after the request
	always @(posedge clk) begin
		rd_pipe[0] <= rd_addr;
		for (int s = 1; s < LAT - 1; s++)
			rd_pipe[s] <= rd_pipe[s-1];
		depth_org <= mem[rd_pipe[LAT-2]];
	end

	always @(negedge clk) begin
		sram_addr_t exp_a;
		pix_mask_t exp_m;
		int due;
		if (!srst_n) begin
			cyc = 0;
		end else begin
			cyc = cyc + 1;
			assert (!raster_top_i.raster_assertions_i.fail_seen)
				else fail_run("a bound protocol assertion failed");
			if (ready_due) begin
				assert (tri_ready) else fail_run("tri_ready did not rise after the last write");
				ready_due = 1'b0;
				busy = 1'b0;
			end else if (busy) begin
				assert (!tri_ready) else fail_run("tri_ready high while a triangle is in flight");
			end
			if (rd_en) begin
				assert (exp_rd_q.size() != 0) else fail_run("tile read outside any bounding box");
				if (!rd_started) begin
					assert (cyc == acc_cyc + 2)
						else report_mismatch("first_read_cycle", acc_cyc + 2, cyc);
				end
				rd_started = 1'b1;
				exp_a = exp_rd_q.pop_front();
				assert (rd_addr == exp_a) else report_mismatch("read_addr", exp_a, rd_addr);
				exp_wr_addr_q.push_back(exp_a);
				exp_wr_mask_q.push_back(expect_mask(exp_tx_q.pop_front(), exp_ty_q.pop_front(),
					mem[exp_a]));
				exp_wr_cyc_q.push_back(cyc + LAT + 1);
			end else if (exp_rd_q.size() != 0 && cyc >= acc_cyc + 2) begin
				fail_run("tile read missing from the row-major walk");
			end
			if (!wr_en_n) begin
				assert (exp_wr_cyc_q.size() != 0) else fail_run("write with no tile read before it");
				due = exp_wr_cyc_q.pop_front();
				exp_a = exp_wr_addr_q.pop_front();
				exp_m = exp_wr_mask_q.pop_front();
				assert (cyc == due) else report_mismatch("write_cycle", due, cyc);
				assert (wr_addr == exp_a) else report_mismatch("write_addr", exp_a, wr_addr);
				assert (wr_mask_n == exp_m) else report_mismatch("write_mask", exp_m, wr_mask_n);
				for (int i = 0; i < PIX; i++) begin
					if (!wr_mask_n[i])
						mem[wr_addr][i*DW +: DW] = depth_after.lane[i];
				end
				pending = pending - 1;
				if (pending == 0)
					ready_due = 1'b1;
			end else if (exp_wr_cyc_q.size() != 0 && cyc >= exp_wr_cyc_q[0]) begin
				fail_run("expected tile write did not come");
			end
			if (tri_valid && tri_ready) begin
				cur_vx = '{int'(x1), int'(x2), int'(x3)};
				cur_vy = '{int'(y1), int'(y2), int'(y3)};
				cur_z = int'(tri_depth);
				plan_tiles();
				acc_cyc = cyc;
				rd_started = 1'b0;
				busy = 1'b1;
			end
		end
	end

	initial begin
		int budget;
		budget = 60; // reset plus margin
		for (int k = 0; k < NUM_TRI; k++)
			budget += box_tiles(k) + 12;
		repeat (budget) @(posedge clk);
		fail_run("timeout, the rasterizer did not finish all triangles");
	end

	initial begin
		void'($urandom(32'hd5d0));
		srst_n = 1'b0;
		tri_valid = 1'b0;
		{x1, y1, x2, y2, x3, y3} = '0;
		tri_depth = '0;
		tri_color = '0;
		depth_org = '0;
		for (int s = 0; s < LAT - 1; s++)
			rd_pipe[s] = '0;
		for (int a = 0; a < WORDS; a++) begin
			for (int i = 0; i < PIX; i++)
				mem[a][i*DW +: DW] = DW'($urandom);
		end
		repeat (10) @(posedge clk);
		srst_n <= 1'b1;
		for (int k = 0; k < NUM_TRI; k++) begin
			repeat ($urandom % 3) @(posedge clk);
			send_triangle(k);
		end
		while (busy || exp_wr_cyc_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		if (!raster_top_i.raster_assertions_i.fail_seen && exp_rd_q.size() == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			fail_run("run ended with pending tiles or failed assertions");
		end
	end

endmodule

// ==== logic/coverage_pipe.sv ====
`timescale 1ns/1ps

`include "raster_config.svh"

module coverage_pipe import raster_pkg::*; (
	input  logic       clk,
	input  logic       srst_n,
	input  logic       tile_valid,
	input  coord_t     tile_x,
	input  coord_t     tile_y,
	input  coord_t     vx1,
	input  coord_t     vy1,
	input  coord_t     vx2,
	input  coord_t     vy2,
	input  coord_t     vx3,
	input  coord_t     vy3,
	input  sram_addr_t rd_addr,
	output logic       cov_valid,
	output pix_mask_t  cov_mask,
	output sram_addr_t cov_addr
);
	localparam int PIX = `RASTER_TILE_PIX;
	localparam int DIM = `RASTER_TILE_DIM;
	localparam int LAT = `RASTER_RD_LATENCY;
	localparam int DW = `RASTER_COORD_W + 2; // room for pixel offset and differences
	localparam int EW = 2 * DW + 1;

	typedef logic signed [DW-1:0] pos_t;
	typedef logic signed [EW-1:0] edge_t;

	pos_t px [PIX];
	pos_t py [PIX];
	edge_t e12 [PIX];
	edge_t e23 [PIX];
	edge_t e31 [PIX];
	pix_mask_t mask_now;

	logic [LAT-1:0] valid_q;
	pix_mask_t mask_q [LAT];
	sram_addr_t addr_q [LAT];

	// cross product of (b - a) and (q - a), sign gives the side of edge a->b
	function automatic edge_t edge_fn(input coord_t ax, input coord_t ay,
			input coord_t bx, input coord_t by, input pos_t qx, input pos_t qy);
		pos_t dx_ab;
		pos_t dy_ab;
		pos_t dx_aq;
		pos_t dy_aq;
		edge_t lhs;
		edge_t rhs;
		dx_ab = pos_t'(bx) - pos_t'(ax);
		dy_ab = pos_t'(by) - pos_t'(ay);
		dx_aq = qx - pos_t'(ax);
		dy_aq = qy - pos_t'(ay);
		lhs = dx_ab * dy_aq;
		rhs = dy_ab * dx_aq;
		return lhs - rhs;
	endfunction

	always_comb begin
		for (int i = 0; i < PIX; i++) begin
			px[i] = pos_t'(tile_x) + pos_t'(i % DIM);
			py[i] = pos_t'(tile_y) + pos_t'(i / DIM);
			e12[i] = edge_fn(vx1, vy1, vx2, vy2, px[i], py[i]);
			e23[i] = edge_fn(vx2, vy2, vx3, vy3, px[i], py[i]);
			e31[i] = edge_fn(vx3, vy3, vx1, vy1, px[i], py[i]);
			// inside for either winding
			mask_now[PIX-1-i] = (e12[i] >= 0 && e23[i] >= 0 && e31[i] >= 0) ||
				(e12[i] <= 0 && e23[i] <= 0 && e31[i] <= 0);
		end
	end

	always_ff @(posedge clk) begin
		if (!srst_n) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= tile_valid;
			for (int s = 1; s < LAT; s++)
				valid_q[s] <= valid_q[s-1];
		end
	end

	// match the sram read latency
	always_ff @(posedge clk) begin
		mask_q[0] <= mask_now;
		addr_q[0] <= rd_addr;
		for (int s = 1; s < LAT; s++) begin
			mask_q[s] <= mask_q[s-1];
			addr_q[s] <= addr_q[s-1];
		end
	end

	assign cov_valid = valid_q[LAT-1];
	assign cov_mask = mask_q[LAT-1];
	assign cov_addr = addr_q[LAT-1];

endmodule

// ==== logic/depth_resolve.sv ====
`timescale 1ns/1ps

`include "raster_config.svh"

module depth_resolve import raster_pkg::*; (
	input  logic        clk,
	input  logic        srst_n,
	input  logic        cov_valid,
	input  pix_mask_t   cov_mask,
	input  sram_addr_t  cov_addr,
	input  tile_depth_u depth_org,
	input  depth_t      hold_depth,
	input  color_t      hold_color,
	output logic        wr_en_n,
	output sram_addr_t  wr_addr,
	output pix_mask_t   wr_mask_n,
	output logic [`RASTER_TILE_PIX*`RASTER_COLOR_W-1:0] color_word,
	output tile_depth_u depth_after
);
	localparam int PIX = `RASTER_TILE_PIX;
	localparam int CW = `RASTER_COLOR_W;

	pix_mask_t draw; // covered and nearer than stored

	always_comb begin
		for (int i = 0; i < PIX; i++)
			draw[i] = cov_mask[i] && (hold_depth < depth_org.lane[i]);
	end

	always_ff @(posedge clk) begin
		if (!srst_n)
			wr_en_n <= 1'b1;
		else
			wr_en_n <= !cov_valid;
	end

	always_ff @(posedge clk) begin
		wr_addr <= cov_addr;
		wr_mask_n <= ~(draw & {PIX{cov_valid}}); // 0 opens the pixel
		// flat shading, same value on every lane
		for (int i = 0; i < PIX; i++) begin
			depth_after.lane[i] <= hold_depth;
			color_word[i*CW +: CW] <= hold_color;
		end
	end

endmodule

// ==== logic/raster_config.svh ====
`ifndef RASTER_CONFIG_SVH
`define RASTER_CONFIG_SVH

// screen coordinates, signed integer pixels
`define RASTER_COORD_W 12

// depth, smaller is nearer
`define RASTER_DEPTH_W 21

`define RASTER_COLOR_W 24 // 8 bits each of r, g, b

// tile geometry
`define RASTER_TILE_DIM 4
`define RASTER_TILE_PIX 16

// 320 pixel wide screen
`define RASTER_TILES_PER_ROW 80

// depth/color sram
`define RASTER_ADDR_W 16
`define RASTER_RD_LATENCY 2 // rd_en to depth_org

`endif

// ==== logic/raster_pkg.sv ====
package raster_pkg;

`include "raster_config.svh"

	// screen position, one axis
	typedef logic signed [`RASTER_COORD_W-1:0] coord_t;

	typedef logic signed [`RASTER_DEPTH_W-1:0] depth_t;

	typedef logic [`RASTER_COLOR_W-1:0] color_t; // r in the top byte

	// one word per 4x4 tile
	typedef logic [`RASTER_ADDR_W-1:0] sram_addr_t;

	// bit 15 is (0,0), row-major down to (3,3) at bit 0
	typedef logic [`RASTER_TILE_PIX-1:0] pix_mask_t;

	// stored depth word of a tile
	// flat at the sram, per pixel lanes in the comparator
	typedef union packed {
		logic [`RASTER_TILE_PIX*`RASTER_DEPTH_W-1:0] flat;
		depth_t [`RASTER_TILE_PIX-1:0] lane; // lane i pairs with mask bit i
	} tile_depth_u;

endpackage

// ==== logic/raster_top.sv ====
`timescale 1ns/1ps

`include "raster_config.svh"

module raster_top import raster_pkg::*; (
	input  logic        clk,
	input  logic        srst_n,
	input  logic        tri_valid,
	output logic        tri_ready,
	input  coord_t      x1,
	input  coord_t      y1,
	input  coord_t      x2,
	input  coord_t      y2,
	input  coord_t      x3,
	input  coord_t      y3,
	input  depth_t      tri_depth,
	input  color_t      tri_color,
	output logic        rd_en,
	output sram_addr_t  rd_addr,
	input  tile_depth_u depth_org,
	output logic        wr_en_n,
	output sram_addr_t  wr_addr,
	output pix_mask_t   wr_mask_n,
	output logic [`RASTER_TILE_PIX*`RASTER_COLOR_W-1:0] color_word,
	output tile_depth_u depth_after
);
	logic tile_valid;
	coord_t tile_x;
	coord_t tile_y;
	coord_t vx1;
	coord_t vy1;
	coord_t vx2;
	coord_t vy2;
	coord_t vx3;
	coord_t vy3;
	depth_t hold_depth;
	color_t hold_color;
	logic cov_valid;
	pix_mask_t cov_mask;
	sram_addr_t cov_addr;

	tile_walker tile_walker_i (
		.clk, .srst_n, .tri_valid, .tri_ready,
		.x1, .y1, .x2, .y2, .x3, .y3, .tri_depth, .tri_color,
		.rd_en, .rd_addr, .tile_valid, .tile_x, .tile_y,
		.vx1, .vy1, .vx2, .vy2, .vx3, .vy3, .hold_depth, .hold_color
	);

	coverage_pipe coverage_pipe_i (
		.clk, .srst_n, .tile_valid, .tile_x, .tile_y,
		.vx1, .vy1, .vx2, .vy2, .vx3, .vy3, .rd_addr,
		.cov_valid, .cov_mask, .cov_addr
	);

	depth_resolve depth_resolve_i (
		.clk, .srst_n, .cov_valid, .cov_mask, .cov_addr, .depth_org,
		.hold_depth, .hold_color,
		.wr_en_n, .wr_addr, .wr_mask_n, .color_word, .depth_after
	);

endmodule

// ==== logic/tile_walker.sv ====
`timescale 1ns/1ps

`include "raster_config.svh"

module tile_walker import raster_pkg::*; (
	input  logic       clk,
	input  logic       srst_n,
	input  logic       tri_valid,
	output logic       tri_ready,
	input  coord_t     x1,
	input  coord_t     y1,
	input  coord_t     x2,
	input  coord_t     y2,
	input  coord_t     x3,
	input  coord_t     y3,
	input  depth_t     tri_depth,
	input  color_t     tri_color,
	output logic       rd_en,
	output sram_addr_t rd_addr,
	output logic       tile_valid,
	output coord_t     tile_x,
	output coord_t     tile_y,
	output coord_t     vx1,
	output coord_t     vy1,
	output coord_t     vx2,
	output coord_t     vy2,
	output coord_t     vx3,
	output coord_t     vy3,
	output depth_t     hold_depth,
	output color_t     hold_color
);
	typedef enum logic [1:0] {IDLE, SETUP, SCAN, DRAIN} state_t;

	localparam int TS = $clog2(`RASTER_TILE_DIM);
	localparam int CNT_W = $clog2(`RASTER_RD_LATENCY + 1);
	localparam coord_t STEP = coord_t'(`RASTER_TILE_DIM);
	localparam sram_addr_t ROW_STRIDE = sram_addr_t'(`RASTER_TILES_PER_ROW);

	state_t state;
	coord_t min_x;
	coord_t min_y;
	coord_t max_x;
	coord_t max_y;
	sram_addr_t row_addr; // address of the first tile in the current row
	logic [CNT_W-1:0] drain_cnt;
	logic scan_q;
	logic last_tile;

	function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
		coord_t m;
		m = (a < b) ? a : b;
		return (c < m) ? c : m;
	endfunction

	function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
		coord_t m;
		m = (a > b) ? a : b;
		return (c > m) ? c : m;
	endfunction

	// round down to the tile grid
	function automatic coord_t snap(input coord_t v);
		return v & ~coord_t'(`RASTER_TILE_DIM - 1);
	endfunction

	function automatic sram_addr_t tile_addr(input coord_t x, input coord_t y);
		return sram_addr_t'(x[`RASTER_COORD_W-1:TS]) +
			sram_addr_t'(y[`RASTER_COORD_W-1:TS]) * ROW_STRIDE;
	endfunction

	assign tri_ready = (state == IDLE);
	assign rd_en = scan_q;
	assign tile_valid = scan_q;
	assign last_tile = (tile_x == max_x) && (tile_y == max_y);

	always_ff @(posedge clk) begin
		if (!srst_n) begin
			state <= IDLE;
			scan_q <= 1'b0;
			drain_cnt <= '0;
		end else begin
			case (state)
			IDLE: begin
				if (tri_valid)
					state <= SETUP;
			end
			SETUP: begin
				state <= SCAN;
				scan_q <= 1'b1;
			end
			SCAN: begin
				if (last_tile) begin
					state <= DRAIN;
					scan_q <= 1'b0;
					drain_cnt <= '0;
				end
			end
			DRAIN: begin
				// wait for the last write to leave depth_resolve
				if (drain_cnt == CNT_W'(`RASTER_RD_LATENCY))
					state <= IDLE;
				else
					drain_cnt <= drain_cnt + 1'b1;
			end
			default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
		IDLE: begin
			if (tri_valid) begin
				vx1 <= x1;
				vy1 <= y1;
				vx2 <= x2;
				vy2 <= y2;
				vx3 <= x3;
				vy3 <= y3;
				hold_depth <= tri_depth;
				hold_color <= tri_color;
				min_x <= snap(min3(x1, x2, x3));
				min_y <= snap(min3(y1, y2, y3));
				max_x <= snap(max3(x1, x2, x3));
				max_y <= snap(max3(y1, y2, y3));
			end
		end
		SETUP: begin
			tile_x <= min_x;
			tile_y <= min_y;
			rd_addr <= tile_addr(min_x, min_y);
			row_addr <= tile_addr(min_x, min_y);
		end
		SCAN: begin
			if (!last_tile) begin
				if (tile_x == max_x) begin // wrap to next row
					tile_x <= min_x;
					tile_y <= tile_y + STEP;
					rd_addr <= row_addr + ROW_STRIDE;
					row_addr <= row_addr + ROW_STRIDE;
				end else begin
					tile_x <= tile_x + STEP;
					rd_addr <= rd_addr + sram_addr_t'(1);
				end
			end
		end
		default: ;
		endcase
	end

endmodule

// ==== raster.f ====
+incdir+logic
logic/raster_pkg.sv
logic/tile_walker.sv
logic/coverage_pipe.sv
logic/depth_resolve.sv
logic/raster_top.sv
bench/raster_assertions.sv
bench/raster_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f raster.f --top-module raster_tb -Mdir obj_dir
./obj_dir/Vraster_tb +verilator+error+limit+100 | tee sim.log

if grep -q "Verification passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi
